/* Bender.yml */
package:
  name: controlpath

sources:
  - hdl/controlPkg.sv
  - hdl/instrMem.sv
  - hdl/fetchDecodeReg.sv
  - hdl/controlDecoder.sv
  - hdl/signExtend.sv
  - hdl/controlPipe.sv
  - hdl/controlTop.sv
  - target: simulation
    files:
      - verif/controlTopAssertions.sv
      - verif/controlTopTb.sv

/* hdl/controlDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
    input  logic [controlPkg::XLEN-1:0] instrD_i,
    output controlPkg::exCtrlT          ctrlD_o,
    output controlPkg::immSrcE          immSrcD_o
);

    import controlPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       subFlag;
    aluCtrlE    aluOp;

    assign opcode  = opcodeE'(instrD_i[6:0]);
    assign funct3  = instrD_i[14:12];
    assign subFlag = (opcode == OP_REG) && instrD_i[30]; // sub only for reg ops

    // alu decoder
    always_comb begin
        case (funct3)
            3'b000:  aluOp = subFlag ? ALU_SUB : ALU_ADD;
            3'b001:  aluOp = ALU_SLL;
            3'b010:  aluOp = ALU_SLT;
            3'b011:  aluOp = ALU_SLT;
            3'b100:  aluOp = ALU_XOR;
            3'b101:  aluOp = ALU_SRL;
            3'b110:  aluOp = ALU_OR;
            default: aluOp = ALU_AND;
        endcase
    end

    // main decoder
    always_comb begin
        ctrlD_o   = '0;
        immSrcD_o = IMM_I;
        case (opcode)
            OP_REG: begin
                ctrlD_o.memCtrl.wbCtrl.regWrite = 1'b1;
                ctrlD_o.aluControl              = aluOp;
            end
            OP_IMM: begin
                ctrlD_o.memCtrl.wbCtrl.regWrite = 1'b1;
                ctrlD_o.aluControl              = aluOp;
                ctrlD_o.aluSrc                  = 1'b1;
            end
            OP_LOAD: begin
                ctrlD_o.memCtrl.wbCtrl.regWrite  = 1'b1;
                ctrlD_o.memCtrl.wbCtrl.resultSrc = RES_MEM;
                ctrlD_o.aluSrc                   = 1'b1;
            end
            OP_STORE: begin
                case (funct3)
                    3'b000:  ctrlD_o.memCtrl.storeSize = ST_BYTE;
                    3'b001:  ctrlD_o.memCtrl.storeSize = ST_HALF;
                    3'b010:  ctrlD_o.memCtrl.storeSize = ST_WORD;
                    default: ctrlD_o.memCtrl.storeSize = ST_NONE;
                endcase
                ctrlD_o.aluSrc = 1'b1;
                immSrcD_o      = IMM_S;
            end
            OP_BRANCH: begin
                ctrlD_o.branch     = 1'b1;
                ctrlD_o.aluControl = ALU_SUB; // compare by subtract
                immSrcD_o          = IMM_B;
            end
            OP_JAL: begin
                ctrlD_o.memCtrl.wbCtrl.regWrite  = 1'b1;
                ctrlD_o.memCtrl.wbCtrl.resultSrc = RES_PC4;
                ctrlD_o.jump                     = 1'b1;
                immSrcD_o                        = IMM_J;
            end
            OP_LUI: begin
                ctrlD_o.memCtrl.wbCtrl.regWrite  = 1'b1;
                ctrlD_o.memCtrl.wbCtrl.resultSrc = RES_IMM;
                ctrlD_o.aluSrc                   = 1'b1;
                immSrcD_o                        = IMM_U;
            end
            default: ctrlD_o = '0; // unknown opcode, bubble
        endcase
        if (opcode inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL, OP_LUI}) begin
            ctrlD_o.funct3 = funct3;
        end
    end

endmodule

`default_nettype wire

/* hdl/controlPipe.sv */
`timescale 1ns/1ns
`default_nettype none

module controlPipe (
    input  logic                  clk,
    input  logic                  rstN_i,
    input  logic                  decEn_i,
    input  logic                  decFlush_i,
    input  controlPkg::exCtrlT    ctrlD_i,
    input  logic                  zeroE_i,
    output controlPkg::aluCtrlE   aluControlE_o,
    output logic                  aluSrcE_o,
    output controlPkg::pcSrcE     pcSrcE_o,
    output controlPkg::storeSizeE storeSizeM_o,
    output controlPkg::wbCtrlT    wbCtrlW_o
);

    import controlPkg::*;

    exCtrlT  ctrlE;
    memCtrlT ctrlM;
    wbCtrlT  ctrlW;
    logic    branchTaken;

    // decode to execute, honours stall and flush
    always_ff @(posedge clk) begin
        if (!rstN_i || decFlush_i) begin
            ctrlE <= '0;
        end else if (decEn_i) begin
            ctrlE <= ctrlD_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            ctrlM <= '0;
            ctrlW <= '0;
        end else begin
            ctrlM <= ctrlE.memCtrl;
            ctrlW <= ctrlM.wbCtrl;
        end
    end

    // funct3[0] flips sense for bne
    assign branchTaken = ctrlE.branch && (zeroE_i ^ ctrlE.funct3[0]);

    always_comb begin
        if (ctrlE.jump) begin
            pcSrcE_o = PC_JUMP;
        end else if (branchTaken) begin
            pcSrcE_o = PC_BRANCH;
        end else begin
            pcSrcE_o = PC_PLUS4;
        end
    end

    assign aluControlE_o = ctrlE.aluControl;
    assign aluSrcE_o     = ctrlE.aluSrc;
    assign storeSizeM_o  = ctrlM.storeSize;
    assign wbCtrlW_o     = ctrlW;

endmodule

`default_nettype wire

/* hdl/controlPkg.sv */
`default_nettype none

package controlPkg;

    localparam int XLEN        = 32;
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam string IMEM_FILE = "program.hex";

    // rv32i major opcodes in the decoded subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } aluCtrlE;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immSrcE;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2,
        RES_IMM = 2'd3
    } resultSrcE;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_BYTE = 2'd1,
        ST_HALF = 2'd2,
        ST_WORD = 2'd3
    } storeSizeE;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2
    } pcSrcE;

    typedef struct packed {
        logic      regWrite;
        resultSrcE resultSrc;
    } wbCtrlT;

    typedef struct packed {
        wbCtrlT    wbCtrl;
        storeSizeE storeSize;
    } memCtrlT;

    // all-zero value is the bubble
    typedef struct packed {
        memCtrlT    memCtrl;
        aluCtrlE    aluControl;
        logic       aluSrc;
        logic       jump;
        logic       branch;
        logic [2:0] funct3;
    } exCtrlT;

endpackage

`default_nettype wire

/* hdl/controlTop.sv */
`timescale 1ns/1ns
`default_nettype none

module controlTop (
    input  logic                        clk,
    input  logic                        rstN_i,
    input  logic                        fetchEn_i,
    input  logic                        fetchFlush_i,
    input  logic                        decEn_i,
    input  logic                        decFlush_i,
    input  logic [controlPkg::XLEN-1:0] pcF_i,
    input  logic                        zeroE_i,
    output logic [controlPkg::XLEN-1:0] instrD_o,
    output logic [controlPkg::XLEN-1:0] pcD_o,
    output logic [controlPkg::XLEN-1:0] pcPlus4D_o,
    output logic [controlPkg::XLEN-1:0] immExtD_o,
    output controlPkg::aluCtrlE         aluControlE_o,
    output logic                        aluSrcE_o,
    output controlPkg::pcSrcE           pcSrcE_o,
    output controlPkg::storeSizeE       storeSizeM_o,
    output controlPkg::wbCtrlT          wbCtrlW_o
);

    import controlPkg::*;

    logic [XLEN-1:0] instrF;
    exCtrlT          ctrlD;
    immSrcE          immSrcD;

    instrMem instrMemInst (
        .pc_i    (pcF_i),
        .instr_o (instrF)
    );

    fetchDecodeReg fetchRegInst (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .en_i       (fetchEn_i),
        .flush_i    (fetchFlush_i),
        .instrF_i   (instrF),
        .pcF_i      (pcF_i),
        .instrD_o   (instrD_o),
        .pcD_o      (pcD_o),
        .pcPlus4D_o (pcPlus4D_o)
    );

    controlDecoder decoderInst (
        .instrD_i  (instrD_o),
        .ctrlD_o   (ctrlD),
        .immSrcD_o (immSrcD)
    );

    signExtend signExtInst (
        .instrD_i  (instrD_o),
        .immSrcD_i (immSrcD),
        .immExtD_o (immExtD_o)
    );

    controlPipe pipeInst (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .decEn_i       (decEn_i),
        .decFlush_i    (decFlush_i),
        .ctrlD_i       (ctrlD),
        .zeroE_i       (zeroE_i),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .pcSrcE_o      (pcSrcE_o),
        .storeSizeM_o  (storeSizeM_o),
        .wbCtrlW_o     (wbCtrlW_o)
    );

endmodule

`default_nettype wire

/* hdl/fetchDecodeReg.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchDecodeReg (
    input  logic                        clk,
    input  logic                        rstN_i,
    input  logic                        en_i,
    input  logic                        flush_i,
    input  logic [controlPkg::XLEN-1:0] instrF_i,
    input  logic [controlPkg::XLEN-1:0] pcF_i,
    output logic [controlPkg::XLEN-1:0] instrD_o,
    output logic [controlPkg::XLEN-1:0] pcD_o,
    output logic [controlPkg::XLEN-1:0] pcPlus4D_o
);

    always_ff @(posedge clk) begin
        if (!rstN_i || flush_i) begin
            // zero instruction decodes as a bubble
            instrD_o   <= '0;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (en_i) begin
            instrD_o   <= instrF_i;
            pcD_o      <= pcF_i;
            pcPlus4D_o <= pcF_i + 32'd4;
        end
    end

endmodule

`default_nettype wire

/* hdl/instrMem.sv */
`timescale 1ns/1ns
`default_nettype none

module instrMem (
    input  logic [controlPkg::XLEN-1:0] pc_i,
    output logic [controlPkg::XLEN-1:0] instr_o
);

    import controlPkg::*;

    logic [XLEN-1:0]        romArray [IMEM_DEPTH];
    logic [IMEM_ADDR_W-1:0] wordIdx;

    initial begin
        $readmemh(IMEM_FILE, romArray);
    end

    // byte address to word index
    assign wordIdx = pc_i[IMEM_ADDR_W+1:2];

    assign instr_o = romArray[wordIdx]; // async read

endmodule

`default_nettype wire

/* hdl/signExtend.sv */
`timescale 1ns/1ns
`default_nettype none

module signExtend (
    input  logic [controlPkg::XLEN-1:0] instrD_i,
    input  controlPkg::immSrcE          immSrcD_i,
    output logic [controlPkg::XLEN-1:0] immExtD_o
);

    import controlPkg::*;

    logic signBit;

    assign signBit = instrD_i[31];

    always_comb begin
        case (immSrcD_i)
            IMM_I: immExtD_o = {{20{signBit}}, instrD_i[31:20]};
            IMM_S: immExtD_o = {{20{signBit}}, instrD_i[31:25], instrD_i[11:7]};
            // branch offsets are halfword aligned
            IMM_B: immExtD_o = {{19{signBit}}, instrD_i[31], instrD_i[7],
                                instrD_i[30:25], instrD_i[11:8], 1'b0};
            IMM_U: immExtD_o = {instrD_i[31:12], 12'b0};
            IMM_J: immExtD_o = {{11{signBit}}, instrD_i[31], instrD_i[19:12],
                                instrD_i[20], instrD_i[30:21], 1'b0};
            default: immExtD_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* program.hex */
// one 32-bit instruction per line, word 0 at pc 0
// add sub addi lw sb sh sw beq bne jal lui and an unknown opcode
002081B3
40208233
FFF00293
00802303
00200223
FE201E23
0020A623
FE208CE3
00209863
FFDFF0EF
123453B7
0000000F

/* src.f */
hdl/controlPkg.sv
hdl/instrMem.sv
hdl/fetchDecodeReg.sv
hdl/controlDecoder.sv
hdl/signExtend.sv
hdl/controlPipe.sv
hdl/controlTop.sv
verif/controlTopAssertions.sv
verif/controlTopTb.sv

/* verif/controlTopAssertions.sv */
`timescale 1ns/1ns
`default_nettype none

module controlTopAssertions (
    input logic                        clk,
    input logic                        rstN_i,
    input logic                        decFlush_i,
    input logic [controlPkg::XLEN-1:0] instrD_o,
    input controlPkg::pcSrcE           pcSrcE_o,
    input controlPkg::storeSizeE       storeSizeM_o
);

    import controlPkg::*;

    pcSrcLegal: assert property (@(posedge clk) disable iff (!rstN_i) pcSrcE_o != 2'd3)
        else $error("pcSrcE_o took the unused encoding 3");

    // reset clears decode and memory stages
    resetClears: assert property (@(posedge clk)
        !rstN_i |=> (instrD_o == '0 && storeSizeM_o == ST_NONE))
        else $error("reset did not clear instrD_o or storeSizeM_o");

    flushNoRedirect: assert property (@(posedge clk) decFlush_i |=> pcSrcE_o == PC_PLUS4)
        else $error("pcSrcE_o redirected after a decode flush");

endmodule

bind controlTop controlTopAssertions assertInst (.*);

`default_nettype wire

/* verif/controlTopTb.sv */
`timescale 1ns/1ns
`default_nettype none

module controlTopTb;

    import controlPkg::*;

    logic            clk;
    logic            rstN_i;
    logic            fetchEn_i;
    logic            fetchFlush_i;
    logic            decEn_i;
    logic            decFlush_i;
    logic [XLEN-1:0] pcF_i;
    logic            zeroE_i;
    logic [XLEN-1:0] instrD_o;
    logic [XLEN-1:0] pcD_o;
    logic [XLEN-1:0] pcPlus4D_o;
    logic [XLEN-1:0] immExtD_o;
    aluCtrlE         aluControlE_o;
    logic            aluSrcE_o;
    pcSrcE           pcSrcE_o;
    storeSizeE       storeSizeM_o;
    wbCtrlT          wbCtrlW_o;

    logic [XLEN-1:0] romImage [IMEM_DEPTH];
    logic [XLEN-1:0] sInstrD;
    logic [XLEN-1:0] sPcD;
    logic [XLEN-1:0] sPcPlus4D;
    exCtrlT          sCtrlE;
    memCtrlT         sCtrlM;
    wbCtrlT          sCtrlW;

    integer seed = 32'hcdce4d1f;
    int     errCount = 0;
    int     testsPassed = 0;
    int     testsFailed = 0;
    int     jumpSeen = 0;
    int     branchSeen = 0;
    bit     checkEn = 1'b0;

    controlTop UUT (.*);

    initial $readmemh(IMEM_FILE, romImage);

    always #10 clk = ~clk;

    // expected decode-stage control word
    function automatic exCtrlT decodeCtrl(input logic [31:0] ins);
        exCtrlT     c;
        logic [2:0] f3;
        aluCtrlE    fnOp;
        c  = '0;
        f3 = ins[14:12];
        case (f3)
            3'd0:       fnOp = ALU_ADD;
            3'd1:       fnOp = ALU_SLL;
            3'd2, 3'd3: fnOp = ALU_SLT;
            3'd4:       fnOp = ALU_XOR;
            3'd5:       fnOp = ALU_SRL;
            3'd6:       fnOp = ALU_OR;
            default:    fnOp = ALU_AND;
        endcase
        case (ins[6:0])
            OP_REG: begin
                c.memCtrl.wbCtrl.regWrite = 1'b1;
                c.aluControl = (f3 == 3'd0 && ins[30]) ? ALU_SUB : fnOp;
            end
            OP_IMM: begin
                c.memCtrl.wbCtrl.regWrite = 1'b1;
                c.aluControl = fnOp;
                c.aluSrc = 1'b1;
            end
            OP_LOAD: begin
                c.memCtrl.wbCtrl = '{regWrite: 1'b1, resultSrc: RES_MEM};
                c.aluSrc = 1'b1;
            end
            OP_STORE: begin
                c.aluSrc = 1'b1;
                case (f3)
                    3'd0:    c.memCtrl.storeSize = ST_BYTE;
                    3'd1:    c.memCtrl.storeSize = ST_HALF;
                    3'd2:    c.memCtrl.storeSize = ST_WORD;
                    default: c.memCtrl.storeSize = ST_NONE;
                endcase
            end
            OP_BRANCH: begin
                c.branch = 1'b1;
                c.aluControl = ALU_SUB;
            end
            OP_JAL: begin
                c.memCtrl.wbCtrl = '{regWrite: 1'b1, resultSrc: RES_PC4};
                c.jump = 1'b1;
            end
            OP_LUI: begin
                c.memCtrl.wbCtrl = '{regWrite: 1'b1, resultSrc: RES_IMM};
                c.aluSrc = 1'b1;
            end
            default: c = '0;
        endcase
        if (c != '0) c.funct3 = f3; // every known opcode sets some field
        return c;
    endfunction

    function automatic logic [31:0] extendImm(input logic [31:0] ins);
        case (ins[6:0])
            OP_STORE:  return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            OP_BRANCH: return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            OP_LUI:    return {ins[31:12], 12'h000};
            OP_JAL:    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default:   return {{20{ins[31]}}, ins[31:20]};
        endcase
    endfunction

    function automatic pcSrcE selectPcSrc(input exCtrlT c, input logic zero);
        if (c.jump) return PC_JUMP;
        if (c.branch && (zero != c.funct3[0])) return PC_BRANCH; // bne inverts
        return PC_PLUS4;
    endfunction

    // shadow pipeline
    always @(posedge clk) begin
        if (!rstN_i || fetchFlush_i) begin
            sInstrD   <= '0;
            sPcD      <= '0;
            sPcPlus4D <= '0;
        end else if (fetchEn_i) begin
            sInstrD   <= romImage[pcF_i[IMEM_ADDR_W+1:2]];
            sPcD      <= pcF_i;
            sPcPlus4D <= pcF_i + 32'd4;
        end
        if (!rstN_i || decFlush_i) sCtrlE <= '0;
        else if (decEn_i) sCtrlE <= decodeCtrl(sInstrD);
        sCtrlM <= rstN_i ? sCtrlE.memCtrl : '0;
        sCtrlW <= rstN_i ? sCtrlM.wbCtrl : '0;
    end

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal)
        else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic compareOutputs();
        pcSrcE expPcSrc;
        expPcSrc = selectPcSrc(sCtrlE, zeroE_i);
        // redirects the DUT really took
        if (expPcSrc == PC_JUMP && pcSrcE_o == PC_JUMP) jumpSeen++;
        if (expPcSrc == PC_BRANCH && pcSrcE_o == PC_BRANCH) branchSeen++;
        checkValue("instrD_o", sInstrD, instrD_o);
        checkValue("pcD_o", sPcD, pcD_o);
        checkValue("pcPlus4D_o", sPcPlus4D, pcPlus4D_o);
        checkValue("immExtD_o", extendImm(sInstrD), immExtD_o);
        checkValue("aluControlE_o", sCtrlE.aluControl, aluControlE_o);
        checkValue("aluSrcE_o", sCtrlE.aluSrc, aluSrcE_o);
        checkValue("pcSrcE_o", expPcSrc, pcSrcE_o);
        checkValue("storeSizeM_o", sCtrlM.storeSize, storeSizeM_o);
        checkValue("wbCtrlW_o", sCtrlW, wbCtrlW_o);
    endtask

    // sample just before each rising edge
    initial begin
        forever begin
            @(negedge clk);
            #9;
            if (checkEn) compareOutputs();
        end
    end

    task automatic driveCycle(input logic fe, input logic ff, input logic de,
                              input logic df, input logic [31:0] pc, input logic zero);
        @(negedge clk);
        fetchEn_i    = fe;
        fetchFlush_i = ff;
        decEn_i      = de;
        decFlush_i   = df;
        pcF_i        = pc;
        zeroE_i      = zero;
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        if (errCount == errsBefore) begin
            testsPassed++;
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d mismatches", name, errCount - errsBefore);
        end
    endtask

    task automatic abortRun(input string why);
        $display("timeout: %s", why);
        $display("test failed");
        $finish;
    endtask

    initial begin
        int          errsBefore;
        int          waitCount;
        int unsigned r;
        clk          = 1'b0;
        rstN_i       = 1'b0;
        fetchEn_i    = 1'b0;
        fetchFlush_i = 1'b0;
        decEn_i      = 1'b0;
        decFlush_i   = 1'b0;
        pcF_i        = '0;
        zeroE_i      = 1'b0;
        repeat (5) @(posedge clk);
        checkEn = 1'b1;

        errsBefore = errCount;
        @(negedge clk);
        rstN_i = 1'b1;
        waitCount = 0;
        while (instrD_o !== '0 || storeSizeM_o !== ST_NONE) begin
            if (waitCount == 10) abortRun("outputs never reached the reset state");
            waitCount++;
            @(posedge clk);
        end
        repeat (2) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
        #9;
        checkValue("instrD_o", '0, instrD_o);
        checkValue("storeSizeM_o", ST_NONE, storeSizeM_o);
        checkValue("wbCtrlW_o.regWrite", 1'b0, wbCtrlW_o.regWrite);
        checkValue("pcSrcE_o", PC_PLUS4, pcSrcE_o);
        finishTest("reset state", errsBefore);

        // sequential walk with zero flag low
        errsBefore = errCount;
        jumpSeen   = 0;
        branchSeen = 0;
        for (int k = 0; k < 12; k++) driveCycle(1'b1, 1'b0, 1'b1, 1'b0, k * 4, 1'b0);
        repeat (5) driveCycle(1'b0, 1'b0, 1'b1, 1'b0, '0, 1'b0); // drain
        finishTest("program walk decode and stage timing", errsBefore);

        // same walk with zero high so beq and bne swap outcomes
        errsBefore = errCount;
        for (int k = 0; k < 12; k++) driveCycle(1'b1, 1'b0, 1'b1, 1'b0, k * 4, 1'b1);
        repeat (5) driveCycle(1'b0, 1'b0, 1'b1, 1'b0, '0, 1'b1);
        assert (jumpSeen >= 2 && branchSeen >= 2)
        else begin
            $display("jal, beq or bne never produced the expected redirect in the walks");
            errCount++;
        end
        finishTest("pc source selection", errsBefore);

        errsBefore = errCount;
        for (int k = 0; k < 400; k++) begin
            r = $random(seed);
            driveCycle(r[2:0] != 3'd0, r[7:4] == 4'd0, r[10:8] != 3'd0, r[15:12] == 4'd0,
                       ((r >> 16) % 12) * 4, r[31]);
        end
        repeat (2) @(negedge clk);
        finishTest("random stalls and flushes", errsBefore);

        checkEn = 1'b0;
        $display("summary: %0d passed, %0d failed", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
